// File: Makefile
# Verilator build of the look-ahead routing testbench

TOP := tb_lookahead_route

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

# the log decides pass or fail
run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: arrival_port_strip.sv
//########################################
// compresses the neighbour's XY port to a
// four-bit code relative to the arrival port
// output is undefined when both ports match,
// which XY routing never produces
//########################################
module arrival_port_strip (
    input  lookahead_pkg::port_onehot_t cur_onehot,
    input  lookahead_pkg::port_onehot_t next_onehot,
    output lookahead_pkg::port_code_t   lk_port
);

    localparam int bin_w      = $clog2(lookahead_pkg::num_ports);     // five-port index
    localparam int code_bin_w = $clog2(lookahead_pkg::num_ports - 1); // four-port index

    // binary index of a one-hot port, zero when no bit is set
    function automatic logic [bin_w-1:0] onehot_to_bin(
        input lookahead_pkg::port_onehot_t oh
    );
        logic [bin_w-1:0] bin;
        bin = '0;
        for (int i = 0; i < lookahead_pkg::num_ports; i++) begin
            if (oh[i]) begin
                bin |= bin_w'(i);
            end
        end
        return bin;
    endfunction

    lookahead_pkg::port_onehot_t arrive_onehot; // port the flit enters the neighbour on
    logic [bin_w-1:0]            arrive_bin;    // r
    logic [bin_w-1:0]            next_bin;      // j
    logic [bin_w-1:0]            strip_bin;     // j with the arrival port removed
    logic [code_bin_w-1:0]       code_bin;

    // leaving east means arriving on the neighbour's west port, and so on
    assign arrive_onehot[lookahead_pkg::port_local] = cur_onehot[lookahead_pkg::port_local];
    assign arrive_onehot[lookahead_pkg::port_east]  = cur_onehot[lookahead_pkg::port_west];
    assign arrive_onehot[lookahead_pkg::port_west]  = cur_onehot[lookahead_pkg::port_east];
    assign arrive_onehot[lookahead_pkg::port_north] = cur_onehot[lookahead_pkg::port_south];
    assign arrive_onehot[lookahead_pkg::port_south] = cur_onehot[lookahead_pkg::port_north];

    assign arrive_bin = onehot_to_bin(arrive_onehot);
    assign next_bin   = onehot_to_bin(next_onehot);

    // ports above the arrival port shift down one place
    assign strip_bin = (arrive_bin > next_bin) ? next_bin : next_bin - 1'b1;
    assign code_bin  = strip_bin[code_bin_w-1:0];

    // back to one-hot over the four remaining ports
    assign lk_port = lookahead_pkg::port_code_t'(1'b1) << code_bin;

endmodule

// File: lookahead_input_stage.sv
//########################################
// input register of the look-ahead stage
// one cycle of latency, no back-pressure
// sw_loc must be a legal port index (0..4)
// cur_port is coded relative to sw_loc
//########################################
module lookahead_input_stage #(
    parameter int unsigned sw_loc = lookahead_pkg::port_local
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        in_valid,
    input  lookahead_pkg::coord_t       dest_x,
    input  lookahead_pkg::coord_t       dest_y,
    input  lookahead_pkg::port_code_t   cur_port,
    output logic                        reg_valid,
    output lookahead_pkg::coord_t       reg_dest_x,
    output lookahead_pkg::coord_t       reg_dest_y,
    output lookahead_pkg::port_onehot_t cur_onehot
);

    lookahead_pkg::port_code_t reg_code; // registered four-bit port code

    // flit fields, all cleared by reset so out_valid starts low
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_valid  <= 1'b0;
            reg_dest_x <= '0;
            reg_dest_y <= '0;
            reg_code   <= '0;
        end else begin
            reg_valid  <= in_valid;
            reg_dest_x <= dest_x;
            reg_dest_y <= dest_y;
            reg_code   <= cur_port;
        end
    end

    // re-insert the port this stage serves as a zero bit
    // bits below sw_loc keep their index, the rest move up by one
    for (genvar i = 0; i < lookahead_pkg::num_ports; i++) begin : g_expand
        if (i < sw_loc) begin : g_low
            assign cur_onehot[i] = reg_code[i];
        end else if (i == sw_loc) begin : g_own
            assign cur_onehot[i] = 1'b0; // a flit never leaves on its input port
        end else begin : g_high
            assign cur_onehot[i] = reg_code[i-1];
        end
    end

endmodule

// File: lookahead_pkg.sv
//########################################
// port numbering and field types shared by
// the look-ahead routing stage
// 2D mesh only, five ports per router
// 4-bit coordinates limit each axis to 16 routers
//########################################
package lookahead_pkg;

    // router port count, local port included
    localparam int num_ports = 5;

    // port indices inside every five-bit one-hot vector
    localparam int port_local = 0;
    localparam int port_east  = 1; // x + 1
    localparam int port_north = 2; // y - 1
    localparam int port_west  = 3; // x - 1
    localparam int port_south = 4; // y + 1

    // coordinate width per axis
    localparam int coord_w = 4;

    // router x or y address
    typedef logic [coord_w-1:0] coord_t;

    // one-hot over all five ports, indexed by the constants above
    typedef logic [num_ports-1:0] port_onehot_t;

    // one-hot over the four ports left once a reference port is dropped.
    // ports above the reference move down by one index
    typedef logic [num_ports-2:0] port_code_t;

endpackage

// File: lookahead_route_top.sv
//########################################
// look-ahead XY routing stage of one mesh
// router input port
// out_valid and lk_port follow in_valid by
// one cycle, a flit is accepted every cycle
// cur_port must never name the local port
//########################################
module lookahead_route_top #(
    parameter int unsigned           nx       = 4,
    parameter int unsigned           ny       = 4,
    parameter lookahead_pkg::coord_t router_x = '0,
    parameter lookahead_pkg::coord_t router_y = '0,
    parameter int unsigned           sw_loc   = lookahead_pkg::port_local
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  lookahead_pkg::coord_t     dest_x,
    input  lookahead_pkg::coord_t     dest_y,
    input  lookahead_pkg::port_code_t cur_port,  // relative to sw_loc
    output logic                      out_valid,
    output lookahead_pkg::port_code_t lk_port    // relative to the neighbour's arrival port
);

    lookahead_pkg::coord_t       reg_dest_x;
    lookahead_pkg::coord_t       reg_dest_y;
    lookahead_pkg::port_onehot_t cur_onehot;  // port chosen here, five-bit
    lookahead_pkg::port_onehot_t next_onehot; // port chosen at the neighbour

    // register stage, valid goes straight out
    lookahead_input_stage #(
        .sw_loc     (sw_loc)
    ) input_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .dest_x     (dest_x),
        .dest_y     (dest_y),
        .cur_port   (cur_port),
        .reg_valid  (out_valid),
        .reg_dest_x (reg_dest_x),
        .reg_dest_y (reg_dest_y),
        .cur_onehot (cur_onehot)
    );

    next_hop_xy_route #(
        .nx          (nx),
        .ny          (ny),
        .router_x    (router_x),
        .router_y    (router_y)
    ) route_i (
        .cur_onehot  (cur_onehot),
        .dest_x      (reg_dest_x),
        .dest_y      (reg_dest_y),
        .next_onehot (next_onehot)
    );

    arrival_port_strip strip_i (
        .cur_onehot  (cur_onehot),
        .next_onehot (next_onehot),
        .lk_port     (lk_port)
    );

endmodule

// File: next_hop_xy_route.sv
//########################################
// predicts the neighbour router address and
// runs XY routing there, combinational
// mesh only, no wrap-around links
// nx, ny at most 16, router_x < nx, router_y < ny
//########################################
module next_hop_xy_route #(
    parameter int unsigned           nx       = 4,
    parameter int unsigned           ny       = 4,
    parameter lookahead_pkg::coord_t router_x = '0,
    parameter lookahead_pkg::coord_t router_y = '0
) (
    input  lookahead_pkg::port_onehot_t cur_onehot,
    input  lookahead_pkg::coord_t       dest_x,
    input  lookahead_pkg::coord_t       dest_y,
    output lookahead_pkg::port_onehot_t next_onehot
);

    // highest address on each axis
    localparam lookahead_pkg::coord_t last_x = lookahead_pkg::coord_t'(nx - 1);
    localparam lookahead_pkg::coord_t last_y = lookahead_pkg::coord_t'(ny - 1);

    // neighbour addresses, constant per router.
    // an edge router has no link past the edge, so the coordinate is held there
    localparam lookahead_pkg::coord_t east_x =
        (router_x < last_x) ? lookahead_pkg::coord_t'(router_x + 1'b1) : router_x;
    localparam lookahead_pkg::coord_t west_x =
        (router_x > 0) ? lookahead_pkg::coord_t'(router_x - 1'b1) : router_x;
    localparam lookahead_pkg::coord_t south_y =
        (router_y < last_y) ? lookahead_pkg::coord_t'(router_y + 1'b1) : router_y;
    localparam lookahead_pkg::coord_t north_y =
        (router_y > 0) ? lookahead_pkg::coord_t'(router_y - 1'b1) : router_y;

    lookahead_pkg::coord_t next_x; // address of the router the flit goes to
    lookahead_pkg::coord_t next_y;

    // one hop in the direction chosen at this router
    always_comb begin
        next_x = router_x;
        next_y = router_y;
        if (cur_onehot[lookahead_pkg::port_east]) begin
            next_x = east_x;
        end else if (cur_onehot[lookahead_pkg::port_west]) begin
            next_x = west_x;
        end else if (cur_onehot[lookahead_pkg::port_north]) begin
            next_y = north_y; // north is towards smaller y
        end else if (cur_onehot[lookahead_pkg::port_south]) begin
            next_y = south_y;
        end
    end

    // XY routing as seen from the neighbour
    // x is resolved first, then y, then the flit is ejected
    always_comb begin
        next_onehot = '0;
        if (dest_x > next_x) begin
            next_onehot[lookahead_pkg::port_east] = 1'b1;
        end else if (dest_x < next_x) begin
            next_onehot[lookahead_pkg::port_west] = 1'b1;
        end else if (dest_y > next_y) begin
            next_onehot[lookahead_pkg::port_south] = 1'b1;
        end else if (dest_y < next_y) begin
            next_onehot[lookahead_pkg::port_north] = 1'b1;
        end else begin
            next_onehot[lookahead_pkg::port_local] = 1'b1; // neighbour is the destination
        end
    end

endmodule

// File: sim.f
+incdir+.
lookahead_pkg.sv
lookahead_input_stage.sv
next_hop_xy_route.sv
arrival_port_strip.sv
lookahead_route_top.sv
tb_lookahead_route.sv

// File: tb_lookahead_ref.svh
//########################################
// expected look-ahead port for one flit
// XY routing in a 2D mesh, five ports
// included inside the testbench module
//########################################
`ifndef TB_LOOKAHEAD_REF_SVH
`define TB_LOOKAHEAD_REF_SVH

// port index (0..4) of a four-bit code that leaves out drop_port, -1 if empty
function automatic int code_to_index(
    input lookahead_pkg::port_code_t code,
    input int                        drop_port
);
    int k;
    k = -1;
    for (int i = 0; i < lookahead_pkg::num_ports - 1; i++) begin
        if (code[i]) begin
            k = i;
        end
    end
    if (k < 0) begin
        return -1;
    end
    return (k < drop_port) ? k : k + 1; // ports above the dropped one sit one lower
endfunction

// four-bit code of port idx, with drop_port taken out of the numbering
function automatic lookahead_pkg::port_code_t index_to_code(
    input int idx,
    input int drop_port
);
    int k;
    k = (idx > drop_port) ? idx - 1 : idx;
    return lookahead_pkg::port_code_t'(1) << k;
endfunction

// XY routing, x first, then y
function automatic int xy_route_index(
    input int from_x,
    input int from_y,
    input int to_x,
    input int to_y
);
    if (to_x > from_x) begin
        return lookahead_pkg::port_east;
    end
    if (to_x < from_x) begin
        return lookahead_pkg::port_west;
    end
    if (to_y > from_y) begin
        return lookahead_pkg::port_south; // south is larger y
    end
    if (to_y < from_y) begin
        return lookahead_pkg::port_north;
    end
    return lookahead_pkg::port_local;
endfunction

// port on which a flit arrives after leaving on out_port
function automatic int mirror_port(input int out_port);
    case (out_port)
        lookahead_pkg::port_east:  return lookahead_pkg::port_west;
        lookahead_pkg::port_west:  return lookahead_pkg::port_east;
        lookahead_pkg::port_north: return lookahead_pkg::port_south;
        lookahead_pkg::port_south: return lookahead_pkg::port_north;
        default:                   return lookahead_pkg::port_local;
    endcase
endfunction

function automatic lookahead_pkg::port_code_t expected_lk_port(
    input int                        here_x,
    input int                        here_y,
    input int                        serve_port,
    input lookahead_pkg::coord_t     dx,
    input lookahead_pkg::coord_t     dy,
    input lookahead_pkg::port_code_t cur_code
);
    int out_port;
    int hop_x;
    int hop_y;
    int next_port;
    int arrive;
    out_port = code_to_index(cur_code, serve_port);
    hop_x = here_x;
    hop_y = here_y;
    case (out_port)
        lookahead_pkg::port_east:  hop_x = here_x + 1;
        lookahead_pkg::port_west:  hop_x = here_x - 1;
        lookahead_pkg::port_north: hop_y = here_y - 1;
        lookahead_pkg::port_south: hop_y = here_y + 1;
        default:                   hop_x = here_x;
    endcase
    next_port = xy_route_index(hop_x, hop_y, int'(dx), int'(dy));
    arrive = mirror_port(out_port);
    return index_to_code(next_port, arrive);
endfunction

`endif

// File: tb_lookahead_route.sv
//########################################
// testbench for the look-ahead stage
// 4x4 mesh, router at (1,2), local input
// destinations never equal the router itself
//########################################
module tb_lookahead_route;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int nx          = 4;
    localparam int ny          = 4;
    localparam int router_x    = 1;
    localparam int router_y    = 2;
    localparam int sw_loc      = lookahead_pkg::port_local;
    localparam int drain_limit = 20; // cycles allowed for results to come back
    localparam int stream_len  = 200;

    logic                      clk;
    logic                      reset;
    logic                      in_valid;
    lookahead_pkg::coord_t     dest_x;
    lookahead_pkg::coord_t     dest_y;
    lookahead_pkg::port_code_t cur_port;
    logic                      out_valid;
    lookahead_pkg::port_code_t lk_port;

    lookahead_pkg::port_code_t expected_q[$]; // one entry per flit in flight
    int checks;
    int errors;
    int test_checks;
    int test_errors;

    `include "tb_lookahead_ref.svh"

    lookahead_route_top #(
        .nx       (nx),
        .ny       (ny),
        .router_x (lookahead_pkg::coord_t'(router_x)),
        .router_y (lookahead_pkg::coord_t'(router_y)),
        .sw_loc   (sw_loc)
    ) dut_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .dest_x    (dest_x),
        .dest_y    (dest_y),
        .cur_port  (cur_port),
        .out_valid (out_valid),
        .lk_port   (lk_port)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string what, input int got, input int expected);
        checks++;
        if (got != expected) begin
            errors++;
            $display("[FAIL] %0t: %s got %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    // outputs sampled on the falling edge, between drive edges
    initial begin : compare
        bit                        last_valid;
        lookahead_pkg::port_code_t expected_code;
        last_valid = 1'b0;
        forever begin
            @(negedge clk);
            if (reset) begin
                check_value("out_valid during reset", int'(out_valid), 0);
                last_valid = 1'b0;
            end else begin
                check_value("out_valid", int'(out_valid), int'(last_valid));
                if (out_valid) begin
                    if (expected_q.size() == 0) begin
                        errors++;
                        $display("at %0t the DUT gave a result with no flit outstanding", $time);
                    end else begin
                        expected_code = expected_q.pop_front();
                        check_value("lk_port", int'(lk_port), int'(expected_code));
                    end
                end
                last_valid = in_valid; // reappears on the next falling edge
            end
        end
    end

    task automatic send_flit(input lookahead_pkg::coord_t dx, input lookahead_pkg::coord_t dy);
        int                        here_port;
        lookahead_pkg::port_code_t code;
        here_port = xy_route_index(router_x, router_y, int'(dx), int'(dy));
        code = index_to_code(here_port, sw_loc);
        @(posedge clk);
        in_valid <= 1'b1;
        dest_x   <= dx;
        dest_y   <= dy;
        cur_port <= code;
        expected_q.push_back(expected_lk_port(router_x, router_y, sw_loc, dx, dy, code));
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // drops valid, then waits for every outstanding result
    task automatic wait_for_results(input string name);
        int cycles;
        idle_cycle();
        cycles = 0;
        while (expected_q.size() != 0 && cycles < drain_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (expected_q.size() != 0) begin
            errors++;
            $display("%s: timed out with %0d results still missing from the DUT",
                     name, expected_q.size());
            expected_q.delete();
        end
    endtask

    task automatic random_stream(input int count);
        lookahead_pkg::coord_t dx;
        lookahead_pkg::coord_t dy;
        for (int i = 0; i < count; i++) begin
            dx = lookahead_pkg::coord_t'($urandom % nx);
            dy = lookahead_pkg::coord_t'($urandom % ny);
            if (int'(dx) == router_x && int'(dy) == router_y) begin
                dx = lookahead_pkg::coord_t'((int'(dx) + 1) % nx); // move off this router
            end
            send_flit(dx, dy);
        end
    endtask

    task automatic start_test();
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic finish_test(input string name);
        $display("[DONE] %s: %0d checks, %0d errors", name,
                 checks - test_checks, errors - test_errors);
    endtask

    initial begin : stimulus
        reset    = 1'b1;
        in_valid = 1'b0;
        dest_x   = '0;
        dest_y   = '0;
        cur_port = '0;
        checks   = 0;
        errors   = 0;
        void'($urandom(32'hfd10));

        start_test();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        repeat (4) idle_cycle(); // valid must stay low with no input
        wait_for_results("reset");
        finish_test("reset");

        // gaps in in_valid come back one cycle later
        start_test();
        send_flit(3, 2);
        idle_cycle();
        send_flit(1, 0);
        send_flit(0, 3);
        idle_cycle();
        idle_cycle();
        send_flit(2, 1);
        idle_cycle();
        send_flit(1, 3);
        wait_for_results("latency");
        finish_test("latency");

        // straight and turning hops
        // south from (1,2) reaches the last row, so it can only end there
        start_test();
        send_flit(3, 2); // east, then east
        send_flit(2, 3); // east, then south
        send_flit(2, 0); // east, then north
        send_flit(0, 0); // west, then north
        send_flit(0, 3); // west, then south
        send_flit(1, 0); // north, then north
        send_flit(1, 3); // south, then local
        wait_for_results("straight and turning");
        finish_test("straight and turning");

        start_test();
        send_flit(2, 2);
        send_flit(0, 2);
        send_flit(1, 1);
        send_flit(1, 3);
        wait_for_results("next hop is destination");
        finish_test("next hop is destination");

        start_test();
        random_stream(stream_len);
        wait_for_results("random stream");
        finish_test("random stream");

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
